// File: build.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_access.sv
rtl/bus_decoder.sv
rtl/block_ram.sv
rtl/sys_registers.sv
rtl/soc_bus_top.sv
testbench/soc_bus_assertions.sv
testbench/soc_bus_checker.sv
testbench/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bus testbench with Verilator from the project root.
# A failed build or a simulation that stops on an assertion also marks the log as failed.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_soc_bus -f build.f \
	&& ./obj_dir/Vtb_soc_bus > sim.log 2>&1 \
	|| echo "TEST FAIL" >> sim.log

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
exit 0

// File: testbench/tb_soc_bus.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module tb_soc_bus;

	import soc_pkg::*;

	localparam logic [1:0] PORT_A    = 2'd0;
	localparam logic [1:0] PORT_B    = 2'd1;
	localparam logic [1:0] PORT_BOTH = 2'd2;

	localparam logic [1:0] KIND_DATA    = 2'd0;
	localparam logic [1:0] KIND_NONZERO = 2'd1;
	localparam logic [1:0] KIND_COUNTER = 2'd2;

	localparam int READY_TIMEOUT = 20;

	// One stimulus row, a port A write is expected back as a read
	typedef struct packed
	{
		logic [1:0]  port;
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [1:0]  kind;
	} row_t;

	logic                      clock;
	logic                      reset;
	logic                      pa_request;
	bus_req_t                  pa;
	bus_rsp_t                  pa_rsp;
	logic                      pb_request;
	bus_req_t                  pb;
	bus_rsp_t                  pb_rsp;
	logic [`SOC_LED_WIDTH-1:0] leds;
	logic [1:0]                row_kind;
	logic                      row_timed;
	int                        checker_errors;
	int                        timeouts;
	int                        seed = 48;
	row_t                      rows [$];

	soc_bus_top DUT
	(
		.clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa(pa),
		.o_pa(pa_rsp),
		.i_pb_request(pb_request),
		.i_pb(pb),
		.o_pb(pb_rsp),
		.o_leds(leds)
	);

	soc_bus_checker u_checker
	(
		.clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa(pa),
		.i_pa_rsp(pa_rsp),
		.i_pb_request(pb_request),
		.i_pb(pb),
		.i_pb_rsp(pb_rsp),
		.i_leds(leds),
		.i_kind(row_kind),
		.i_timed(row_timed),
		.o_errors(checker_errors)
	);

	bind bus_access soc_bus_assertions u_assertions
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_bus_request(o_bus_request),
		.i_bus(i_bus),
		.i_pa(o_pa),
		.i_pb(o_pb)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic add_row(input logic [1:0] port, input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, input logic [1:0] kind);
		row_t row;
		row.port = port;
		row.rw = rw;
		row.address = address;
		row.wdata = wdata;
		row.kind = kind;
		rows.push_back(row);
	endtask

	//====================
	// Stimulus table
	//====================

	task automatic build_table();
		// RAM writes, then reads from both ports
		add_row(PORT_B, 1'b1, 32'h0000_0000, $random(seed), KIND_DATA);
		add_row(PORT_B, 1'b1, 32'h0000_0004, $random(seed), KIND_DATA);
		add_row(PORT_B, 1'b1, 32'h0001_fffc, $random(seed), KIND_DATA);
		add_row(PORT_B, 1'b1, 32'h0000_0100, $random(seed), KIND_DATA);
		add_row(PORT_B, 1'b0, 32'h0000_0000, 32'd0, KIND_DATA);
		add_row(PORT_A, 1'b0, 32'h0000_0004, 32'd0, KIND_DATA);
		add_row(PORT_A, 1'b0, 32'h0001_fffc, 32'd0, KIND_DATA);
		add_row(PORT_B, 1'b0, 32'h0000_0100, 32'd0, KIND_DATA);
		// LED register
		add_row(PORT_B, 1'b1, 32'h5000_0000, 32'hffff_f2a5, KIND_DATA);
		add_row(PORT_B, 1'b0, 32'h5000_0000, 32'd0, KIND_DATA);
		add_row(PORT_A, 1'b0, 32'h5000_0000, 32'd0, KIND_DATA);
		// Instruction port cannot write the LED register
		add_row(PORT_A, 1'b1, 32'h5000_0000, 32'h0000_015a, KIND_DATA);
		// Cycle counter keeps running through a write
		add_row(PORT_B, 1'b0, 32'h5000_0004, 32'd0, KIND_NONZERO);
		add_row(PORT_B, 1'b1, 32'h5000_0004, 32'd0, KIND_DATA);
		add_row(PORT_A, 1'b0, 32'h5000_0004, 32'd0, KIND_COUNTER);
		add_row(PORT_B, 1'b0, 32'h5000_000c, 32'd0, KIND_DATA);
		// Unmapped addresses, then the bus again
		add_row(PORT_B, 1'b0, 32'h3000_0000, 32'd0, KIND_DATA);
		add_row(PORT_A, 1'b0, 32'h5000_0010, 32'd0, KIND_DATA);
		add_row(PORT_B, 1'b1, 32'h8000_0000, $random(seed), KIND_DATA);
		add_row(PORT_B, 1'b0, 32'h0000_0000, 32'd0, KIND_DATA);
		// Both ports at once, port B goes first
		add_row(PORT_BOTH, 1'b1, 32'h0000_0008, $random(seed), KIND_DATA);
		add_row(PORT_BOTH, 1'b0, 32'h0000_0004, 32'd0, KIND_DATA);
		add_row(PORT_BOTH, 1'b0, 32'h5000_0004, 32'd0, KIND_COUNTER);
		add_row(PORT_A, 1'b0, 32'h0001_fffc, 32'd0, KIND_DATA);
	endtask

	// Drives one row on a falling edge and waits for each port's ready
	task automatic apply_row(input row_t row, input int index);
		logic wait_a;
		logic wait_b;
		int   cycles;
		@(negedge clock);
		wait_a = (row.port == PORT_A) || (row.port == PORT_BOTH);
		wait_b = (row.port == PORT_B) || (row.port == PORT_BOTH);
		row_kind = row.kind;
		row_timed = (row.port != PORT_BOTH);
		if (wait_a)
		begin
			pa.rw = row.rw;
			pa.address = row.address;
			pa.wdata = row.wdata;
			pa_request = 1'b1;
		end
		if (wait_b)
		begin
			pb.rw = row.rw;
			pb.address = row.address;
			pb.wdata = row.wdata;
			pb_request = 1'b1;
		end
		cycles = 0;
		while ((wait_a || wait_b) && (cycles < READY_TIMEOUT))
		begin
			@(negedge clock);
			cycles++;
			if (wait_a && pa_rsp.ready)
			begin
				pa_request = 1'b0;
				wait_a = 1'b0;
			end
			if (wait_b && pb_rsp.ready)
			begin
				pb_request = 1'b0;
				wait_b = 1'b0;
			end
		end
		if (wait_a || wait_b)
		begin
			$display("timeout: no ready for table row %0d after %0d cycles", index, cycles);
			timeouts++;
			pa_request = 1'b0;
			pb_request = 1'b0;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		pa_request = 1'b0;
		pa = '0;
		pb_request = 1'b0;
		pb = '0;
		row_kind = KIND_DATA;
		row_timed = 1'b0;
		timeouts = 0;
		build_table();
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++)
		begin
			apply_row(rows[i], i);
			if (timeouts != 0)
				break;
		end
		repeat (4) @(negedge clock);
		$display("errors: checker %0d, timeouts %0d", checker_errors, timeouts);
		if ((checker_errors == 0) && (timeouts == 0))
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: testbench/soc_bus_checker.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module soc_bus_checker
(
	input  logic                       clock,
	input  logic                       i_reset,
	input  logic                       i_pa_request,
	input  soc_pkg::bus_req_t          i_pa,
	input  soc_pkg::bus_rsp_t          i_pa_rsp,
	input  logic                       i_pb_request,
	input  soc_pkg::bus_req_t          i_pb,
	input  soc_pkg::bus_rsp_t          i_pb_rsp,
	input  logic [`SOC_LED_WIDTH-1:0]  i_leds,
	input  logic [1:0]                 i_kind,
	input  logic                       i_timed,
	output int                         o_errors
);

	import soc_pkg::*;

	localparam logic [1:0] KIND_DATA    = 2'd0;
	localparam logic [1:0] KIND_NONZERO = 2'd1;
	localparam logic [1:0] KIND_COUNTER = 2'd2;

	// Shadow of RAM words written so far, keyed by word address
	logic [31:0]               shadow_mem [logic [29:0]];
	logic [`SOC_LED_WIDTH-1:0] shadow_leds;
	logic [31:0]               last_counter;
	int                        pa_edges;
	int                        pb_edges;
	// Set while a joint request still owes the port B answer
	logic                      pb_first;

	// Instruction port transfers are always reads
	function automatic bus_req_t as_read(input bus_req_t req);
		bus_req_t result;
		result = req;
		result.rw = 1'b0;
		return result;
	endfunction

	task automatic check_transfer(input string name, input bus_req_t req,
		input bus_rsp_t rsp, input int edges);
		logic [29:0] word;
		logic [1:0]  offset;
		logic        is_mem;
		logic        is_sys;
		logic        known;
		logic [31:0] expected;
		word = req.address[31:2];
		offset = req.address[3:2];
		is_mem = (req.address - `SOC_MEM_BASE) < (`SOC_MEM_LIMIT - `SOC_MEM_BASE);
		is_sys = (req.address - `SOC_SYS_BASE) < (`SOC_SYS_LIMIT - `SOC_SYS_BASE);
		if (i_timed && (edges != 3))
		begin
			$display("%s ready came %0d edges after the request instead of 3", name, edges);
			o_errors = o_errors + 1;
		end
		if (req.rw)
		begin
			if (is_mem)
				shadow_mem[word] = req.wdata;
			else if (is_sys && (offset == 2'd0))
				shadow_leds = req.wdata[`SOC_LED_WIDTH-1:0];
		end
		else if (is_sys && (offset == 2'd1))
		begin
			// Cycle counter, only its growth is known
			if ((i_kind == KIND_NONZERO) && (rsp.rdata == 32'd0))
			begin
				$display("%s read the cycle counter as zero", name);
				o_errors = o_errors + 1;
			end
			if ((i_kind == KIND_COUNTER) && (rsp.rdata <= last_counter))
			begin
				$display("cycle counter did not grow: %08h after %08h", rsp.rdata, last_counter);
				o_errors = o_errors + 1;
			end
			last_counter = rsp.rdata;
		end
		else if (i_kind == KIND_DATA)
		begin
			known = 1'b1;
			expected = 32'd0;
			if (is_mem)
			begin
				known = 1'b0;
				if (shadow_mem.exists(word))
				begin
					known = 1'b1;
					expected = shadow_mem[word];
				end
			end
			else if (is_sys && (offset == 2'd0))
				expected = {{(32 - `SOC_LED_WIDTH){1'b0}}, shadow_leds};
			if (known && (rsp.rdata !== expected))
			begin
				$display("mismatch %s.rdata at address %08h: got %08h, expected %08h",
					name, req.address, rsp.rdata, expected);
				o_errors = o_errors + 1;
			end
		end
	endtask

	//====================
	// Sampling
	//====================

	// Sampled on the rising edge, before the DUT registers update
	always @(posedge clock)
	begin
		if (i_reset)
		begin
			shadow_mem.delete();
			shadow_leds = '0;
			last_counter = 32'd0;
			pa_edges = 0;
			pb_edges = 0;
			pb_first = 1'b0;
			o_errors = 0;
		end
		else
		begin
			// Both ports raised in the same cycle, port B has priority
			if (i_pa_request && i_pb_request && (pa_edges == 0) && (pb_edges == 0))
				pb_first = 1'b1;
			if (i_pa_rsp.ready)
			begin
				if (pb_first)
				begin
					$display("port A finished before port B although both requested together");
					o_errors = o_errors + 1;
				end
				check_transfer("o_pa", as_read(i_pa), i_pa_rsp, pa_edges + 1);
				pa_edges = 0;
			end
			else if (i_pa_request)
				pa_edges = pa_edges + 1;
			if (i_pb_rsp.ready)
			begin
				pb_first = 1'b0;
				check_transfer("o_pb", i_pb, i_pb_rsp, pb_edges + 1);
				pb_edges = 0;
			end
			else if (i_pb_request)
				pb_edges = pb_edges + 1;
			// LED register is already updated on its ready edge
			if (i_leds !== shadow_leds)
			begin
				$display("mismatch o_leds: got %03h, expected %03h", i_leds, shadow_leds);
				o_errors = o_errors + 1;
			end
		end
	end

endmodule

// File: testbench/soc_bus_assertions.sv
`timescale 1ns/100ps

module soc_bus_assertions
(
	input  logic               clock,
	input  logic               i_reset,
	input  logic               i_bus_request,
	input  soc_pkg::bus_rsp_t  i_bus,
	input  soc_pkg::bus_rsp_t  i_pa,
	input  soc_pkg::bus_rsp_t  i_pb
);

	//====================
	// Handshake rules
	//====================

	// Each transfer is acknowledged once
	bus_ready_pulse: assert property (@(posedge clock) disable iff (i_reset)
		i_bus.ready |=> !i_bus.ready)
		else $error("bus ready stayed high for two cycles");

	port_a_ready_pulse: assert property (@(posedge clock) disable iff (i_reset)
		i_pa.ready |=> !i_pa.ready)
		else $error("port A ready stayed high for two cycles");

	port_b_ready_pulse: assert property (@(posedge clock) disable iff (i_reset)
		i_pb.ready |=> !i_pb.ready)
		else $error("port B ready stayed high for two cycles");

	// Only the granted port sees ready
	ready_one_port: assert property (@(posedge clock) disable iff (i_reset)
		!(i_pa.ready && i_pb.ready))
		else $error("port A and port B ready high in the same cycle");

	// Arbiter sits idle through reset
	request_low_in_reset: assert property (@(posedge clock)
		i_reset |=> !i_bus_request)
		else $error("bus request high after a reset cycle");

endmodule

// File: rtl/soc_bus_top.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module soc_bus_top
(
	input  logic                       clock,
	input  logic                       i_reset,

	input  logic                       i_pa_request,
	input  soc_pkg::bus_req_t          i_pa,
	output soc_pkg::bus_rsp_t          o_pa,

	input  logic                       i_pb_request,
	input  soc_pkg::bus_req_t          i_pb,
	output soc_pkg::bus_rsp_t          o_pb,

	output logic [`SOC_LED_WIDTH-1:0]  o_leds
);

	import soc_pkg::*;

	// Single-port bus
	logic     bus_request;
	bus_req_t bus;
	bus_rsp_t bus_rsp;

	// Target side
	logic     mem_request;
	logic     sys_request;
	bus_rsp_t mem_rsp;
	bus_rsp_t sys_rsp;

	bus_access u_bus_access
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa(i_pa),
		.o_pa(o_pa),
		.i_pb_request(i_pb_request),
		.i_pb(i_pb),
		.o_pb(o_pb),
		.o_bus_request(bus_request),
		.o_bus(bus),
		.i_bus(bus_rsp)
	);

	bus_decoder u_bus_decoder
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(bus_request),
		.i_bus(bus),
		.o_bus(bus_rsp),
		.o_mem_request(mem_request),
		.o_sys_request(sys_request),
		.i_mem(mem_rsp),
		.i_sys(sys_rsp)
	);

	//====================
	// Targets
	//====================

	block_ram #(
		.WORDS(`SOC_RAM_WORDS)
	) u_block_ram
	(
		.clock(clock),
		.i_request(mem_request),
		.i_bus(bus),
		.o_bus(mem_rsp)
	);

	sys_registers u_sys_registers
	(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(sys_request),
		.i_bus(bus),
		.o_bus(sys_rsp),
		.o_leds(o_leds)
	);

endmodule

// File: rtl/sys_registers.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module sys_registers
(
	input  logic                       clock,
	input  logic                       i_reset,
	input  logic                       i_request,
	input  soc_pkg::bus_req_t          i_bus,
	output soc_pkg::bus_rsp_t          o_bus,
	output logic [`SOC_LED_WIDTH-1:0]  o_leds
);

	localparam logic [1:0] OFFSET_LEDS  = 2'd0;
	localparam logic [1:0] OFFSET_CYCLE = 2'd1;

	logic [`SOC_LED_WIDTH-1:0] led_q;
	logic [31:0]               cycle_q;
	logic [31:0]               rdata_q;
	logic                      ready_q;
	logic                      accept;
	logic [1:0]                offset;

	// Window is four words wide
	assign offset = i_bus.address[3:2];
	assign accept = i_request && !ready_q;

	//====================
	// Registers
	//====================

	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			led_q <= '0;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= accept;
			if (accept && i_bus.rw && (offset == OFFSET_LEDS))
				led_q <= i_bus.wdata[`SOC_LED_WIDTH-1:0];
		end
	end

	// Free-running cycle counter, writes have no effect
	always_ff @(posedge clock)
	begin
		if (i_reset)
			cycle_q <= `SOC_CYCLE_RESET;
		else
			cycle_q <= cycle_q + 32'd1;
	end

	// Read data sampled with the request
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			case (offset)
				OFFSET_LEDS:
					rdata_q <= {{(32 - `SOC_LED_WIDTH){1'b0}}, led_q};
				OFFSET_CYCLE:
					rdata_q <= cycle_q;
				default:
					rdata_q <= 32'd0;
			endcase
		end
	end

	assign o_bus.rdata = rdata_q;
	assign o_bus.ready = ready_q;
	assign o_leds = led_q;

endmodule

// File: rtl/block_ram.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module block_ram
#(
	parameter int WORDS = `SOC_RAM_WORDS
)
(
	input  logic               clock,
	input  logic               i_request,
	input  soc_pkg::bus_req_t  i_bus,
	output soc_pkg::bus_rsp_t  o_bus
);

	localparam int ADDR_BITS = $clog2(WORDS);

	logic [31:0]          mem [0:WORDS-1];
	logic [ADDR_BITS-1:0] word_index;
	logic [31:0]          rdata_q;
	logic                 ready_q;
	logic                 accept;

	// Byte address to word index
	assign word_index = i_bus.address[ADDR_BITS+1:2];

	// A held request is taken once, the cycle after the answer is skipped
	assign accept = i_request && !ready_q;

	always_ff @(posedge clock)
	begin
		ready_q <= accept;
	end

	// Read returns the word before any write in the same cycle
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			rdata_q <= mem[word_index];
			if (i_bus.rw)
				mem[word_index] <= i_bus.wdata;
		end
	end

	assign o_bus.rdata = rdata_q;
	assign o_bus.ready = ready_q;

endmodule

// File: rtl/bus_decoder.sv
`timescale 1ns/100ps

`include "soc_cfg.svh"

module bus_decoder
(
	input  logic               clock,
	input  logic               i_reset,

	// From the arbiter
	input  logic               i_request,
	input  soc_pkg::bus_req_t  i_bus,
	output soc_pkg::bus_rsp_t  o_bus,

	// Target side
	output logic               o_mem_request,
	output logic               o_sys_request,
	input  soc_pkg::bus_rsp_t  i_mem,
	input  soc_pkg::bus_rsp_t  i_sys
);

	import soc_pkg::*;

	target_sel_t sel;
	logic [31:0] mem_offset;
	logic [31:0] sys_offset;
	logic        none_ready;

	// Range checks on offsets from each base
	assign mem_offset = i_bus.address - `SOC_MEM_BASE;
	assign sys_offset = i_bus.address - `SOC_SYS_BASE;

	always_comb
	begin
		if (mem_offset < (`SOC_MEM_LIMIT - `SOC_MEM_BASE))
			sel = TARGET_MEM;
		else if (sys_offset < (`SOC_SYS_LIMIT - `SOC_SYS_BASE))
			sel = TARGET_SYS;
		else
			sel = TARGET_NONE;
	end

	assign o_mem_request = i_request && (sel == TARGET_MEM);
	assign o_sys_request = i_request && (sel == TARGET_SYS);

	//====================
	// Unmapped addresses
	//====================

	// Answer once so the bus cannot hang
	always_ff @(posedge clock)
	begin
		if (i_reset)
			none_ready <= 1'b0;
		else
			none_ready <= i_request && (sel == TARGET_NONE) && !none_ready;
	end

	// Response back to the arbiter
	always_comb
	begin
		o_bus = '0;
		case (sel)
			TARGET_MEM:
				o_bus = i_mem;
			TARGET_SYS:
				o_bus = i_sys;
			default:
				o_bus.ready = none_ready;
		endcase
		o_bus.ready = o_bus.ready && i_request;
	end

endmodule

// File: rtl/bus_access.sv
`timescale 1ns/100ps

module bus_access
(
	input  logic               clock,
	input  logic               i_reset,

	// Port A, instruction fetch, read only
	input  logic               i_pa_request,
	input  soc_pkg::bus_req_t  i_pa,
	output soc_pkg::bus_rsp_t  o_pa,

	// Port B, data access
	input  logic               i_pb_request,
	input  soc_pkg::bus_req_t  i_pb,
	output soc_pkg::bus_rsp_t  o_pb,

	// Single-port bus
	output logic               o_bus_request,
	output soc_pkg::bus_req_t  o_bus,
	input  soc_pkg::bus_rsp_t  i_bus
);

	import soc_pkg::*;

	typedef enum logic [1:0]
	{
		ST_IDLE    = 2'd0,
		ST_GRANT_A = 2'd1,
		ST_GRANT_B = 2'd2
	} state_t;

	state_t   state;
	bus_req_t bus_q;
	bus_req_t pa_read;

	// Instruction port never writes
	always_comb
	begin
		pa_read = i_pa;
		pa_read.rw = 1'b0;
	end

	//====================
	// Grant FSM
	//====================

	// Port B wins when both ask in the same cycle
	always_ff @(posedge clock)
	begin
		if (i_reset)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (i_pb_request)
						state <= ST_GRANT_B;
					else if (i_pa_request)
						state <= ST_GRANT_A;
				end
				default:
				begin
					// One idle cycle after every transfer
					if (i_bus.ready)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// Transfer captured at grant, held until ready
	always_ff @(posedge clock)
	begin
		if (state == ST_IDLE)
		begin
			if (i_pb_request)
				bus_q <= i_pb;
			else if (i_pa_request)
				bus_q <= pa_read;
		end
	end

	assign o_bus_request = (state != ST_IDLE);
	assign o_bus = bus_q;

	//====================
	// Response routing
	//====================

	always_comb
	begin
		o_pa = '0;
		o_pb = '0;
		if (state == ST_GRANT_A)
			o_pa = i_bus;
		if (state == ST_GRANT_B)
			o_pb = i_bus;
	end

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

	// One bus transfer as driven by a requester
	typedef struct packed
	{
		logic        rw;       // 1 is a write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Target answer, ready is a single-cycle pulse
	typedef struct packed
	{
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	// Targets on the single-port bus
	typedef enum logic [1:0]
	{
		TARGET_MEM  = 2'd0,
		TARGET_SYS  = 2'd1,
		TARGET_NONE = 2'd2
	} target_sel_t;

endpackage

// File: rtl/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//====================
// Address map
//====================

// ROM and RAM windows share one block RAM
`define SOC_MEM_BASE     32'h00000000
`define SOC_MEM_LIMIT    32'h00020000

// LED register and cycle counter
`define SOC_SYS_BASE     32'h50000000
`define SOC_SYS_LIMIT    32'h50000010

//====================
// Targets
//====================

// Depth in 32-bit words, fills the memory window
`define SOC_RAM_WORDS    32768

`define SOC_LED_WIDTH    10

`define SOC_CYCLE_RESET  32'd0

`endif
